// ==== compile.f ====
+incdir+design
design/wb_arch_pkg.sv
design/wb_uop_pkg.sv
design/wb_uop_if.sv
design/wb_latch.sv
design/wb_resolve.sv
design/wb_commit.sv
design/writeback_top.sv
test/writeback_properties.sv
test/writeback_tb.sv

// ==== design/wb_arch_pkg.sv ====
`include "wb_settings.svh"

package wb_arch_pkg;

   // general register number
   typedef logic [`WB_REG_W-1:0] reg_idx_t;

   // positions in the x86 flags word
   localparam int CF_BIT = 0;
   localparam int ZF_BIT = 6;
   localparam int SF_BIT = 7;
   localparam int OF_BIT = 11;

endpackage

// ==== design/wb_commit.sv ====
`include "wb_settings.svh"

module wb_commit (
   input  logic                  CLK,
   input  logic                  rst_n,
   wb_commit_if.dst              cmt,
   output logic                  gpr_we,
   output wb_arch_pkg::reg_idx_t gpr_dr,
   output logic [`WB_DATA_W-1:0] gpr_data,
   output logic                  eip_we,
   output logic [`WB_DATA_W-1:0] eip,
   output logic                  dc_write,
   output logic [`WB_DATA_W-1:0] dc_address,
   output logic [`WB_DATA_W-1:0] dc_data,
   input  logic                  dc_ready
);

   logic xfer;

   // a held store blocks until the cache takes it
   assign cmt.ready = !dc_write || dc_ready;
   assign xfer      = cmt.valid && cmt.ready;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         gpr_we   <= 1'b0;
         eip_we   <= 1'b0;
         dc_write <= 1'b0;
      end else begin
         // single cycle pulses
         gpr_we <= xfer && cmt.gpr_we;
         eip_we <= xfer && cmt.eip_we;
         if (xfer) begin
            dc_write <= cmt.st_req;
         end else if (dc_ready) begin
            dc_write <= 1'b0;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (xfer) begin
         gpr_dr   <= cmt.gpr_dr;
         gpr_data <= cmt.gpr_data;
         eip      <= cmt.eip;
      end
      // address and data stay put while a store waits
      if (xfer && cmt.st_req) begin
         dc_address <= cmt.st_addr;
         dc_data    <= cmt.st_data;
      end
   end

endmodule

// ==== design/wb_latch.sv ====
`include "wb_settings.svh"

module wb_latch (
   input  logic                  CLK,
   input  logic                  rst_n,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  wb_uop_pkg::wb_ctrl_u  in_ctrl,
   input  logic [`WB_DATA_W-1:0] in_result_a,
   input  logic [`WB_DATA_W-1:0] in_result_c,
   input  logic [`WB_DATA_W-1:0] in_alu_flags,
   input  logic [`WB_DATA_W-1:0] in_address,
   input  logic [`WB_DATA_W-1:0] in_neip,
   input  logic [`WB_DATA_W-1:0] in_neip_not_taken,
   wb_uop_if.src                 uop
);

   logic active;
   logic full;

   // open one cycle after reset, then take a new item when empty or draining
   assign in_ready  = active && (!full || uop.ready);
   assign uop.valid = full;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         active <= 1'b0;
         full   <= 1'b0;
      end else begin
         active <= 1'b1;
         if (in_valid && in_ready) begin
            full <= 1'b1;
         end else if (uop.ready) begin
            full <= 1'b0;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (in_valid && in_ready) begin
         uop.ctrl           <= in_ctrl;
         uop.result_a       <= in_result_a;
         uop.result_c       <= in_result_c;
         uop.alu_flags      <= in_alu_flags;
         uop.address        <= in_address;
         uop.neip           <= in_neip;
         uop.neip_not_taken <= in_neip_not_taken;
      end
   end

endmodule

// ==== design/wb_resolve.sv ====
`include "wb_settings.svh"

module wb_resolve (
   input  logic                  CLK,
   input  logic                  rst_n,
   wb_uop_if.dst                 uop,
   wb_commit_if.src              cmt,
   output logic [`WB_DATA_W-1:0] flags,
   output logic                  halted
);

   localparam int FLAG_POS [4] = '{wb_arch_pkg::CF_BIT, wb_arch_pkg::ZF_BIT,
                                   wb_arch_pkg::SF_BIT, wb_arch_pkg::OF_BIT};

   wb_uop_pkg::uop_kind_t kind;
   wb_uop_pkg::alu_view_t alu;
   wb_uop_pkg::br_view_t  br;
   logic [`WB_DATA_W-1:0] flags_q;
   logic [`WB_DATA_W-1:0] merged;
   logic                  halted_q;
   logic                  taken;
   logic                  xfer;

   // kind is common to both views
   assign kind = uop.ctrl.alu.kind;
   assign alu  = uop.ctrl.alu;
   assign br   = uop.ctrl.br;

   assign cmt.valid = uop.valid && !halted_q;
   assign uop.ready = cmt.ready && !halted_q;
   assign xfer      = cmt.valid && cmt.ready;

   // conditions see the flags before this item updates them
   always_comb begin
      case (br.cond)
         wb_uop_pkg::COND_ALWAYS: taken = 1'b1;
         wb_uop_pkg::COND_JNE:    taken = !flags_q[wb_arch_pkg::ZF_BIT];
         wb_uop_pkg::COND_JNBE:   taken = !flags_q[wb_arch_pkg::CF_BIT] &&
                                          !flags_q[wb_arch_pkg::ZF_BIT];
         default:                 taken = 1'b0;
      endcase
   end

   // take only the affected bits from the alu
   always_comb begin
      merged = flags_q;
      for (int i = 0; i < 4; i++) begin
         if (alu.flags_mask[i]) begin
            merged[FLAG_POS[i]] = uop.alu_flags[FLAG_POS[i]];
         end
      end
   end

   // cmovc writes only with carry set
   assign cmt.gpr_we   = uop.valid && (kind == wb_uop_pkg::KIND_ALU) && alu.ld_gpr &&
                         (!alu.cmovc || flags_q[wb_arch_pkg::CF_BIT]);
   assign cmt.gpr_dr   = alu.dr;
   assign cmt.gpr_data = uop.result_c;

   assign cmt.eip_we   = uop.valid && (kind == wb_uop_pkg::KIND_BRANCH);
   assign cmt.eip      = taken ? uop.neip : uop.neip_not_taken;

   assign cmt.st_req   = uop.valid && (kind == wb_uop_pkg::KIND_STORE);
   assign cmt.st_addr  = uop.address;
   assign cmt.st_data  = uop.result_a;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         flags_q  <= `WB_FLAGS_RESET;
         halted_q <= 1'b0;
      end else if (xfer) begin
         if (kind == wb_uop_pkg::KIND_ALU && alu.ld_flags) begin
            // popf loads the whole word
            flags_q <= alu.pop_flags ? uop.result_a : merged;
         end
         if (kind == wb_uop_pkg::KIND_HALT) begin
            halted_q <= 1'b1;
         end
      end
   end

   assign flags  = flags_q;
   assign halted = halted_q;

endmodule

// ==== design/wb_settings.svh ====
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// data path and address width
`define WB_DATA_W 32

// general register number width, eight registers
`define WB_REG_W 3

// bit 1 of the x86 flags reads as one
`define WB_FLAGS_RESET 32'h0000_0002

`endif

// ==== design/wb_uop_if.sv ====
`include "wb_settings.svh"

// latch to resolve
interface wb_uop_if;
   logic                   valid;
   logic                   ready;
   wb_uop_pkg::wb_ctrl_u   ctrl;
   logic [`WB_DATA_W-1:0]  result_a;
   logic [`WB_DATA_W-1:0]  result_c;
   logic [`WB_DATA_W-1:0]  alu_flags;
   logic [`WB_DATA_W-1:0]  address;
   logic [`WB_DATA_W-1:0]  neip;
   logic [`WB_DATA_W-1:0]  neip_not_taken;

   modport src (output valid, ctrl, result_a, result_c, alu_flags, address, neip,
                       neip_not_taken,
                input  ready);
   modport dst (input  valid, ctrl, result_a, result_c, alu_flags, address, neip,
                       neip_not_taken,
                output ready);
endinterface

// resolve to commit
interface wb_commit_if;
   logic                   valid;
   logic                   ready;
   logic                   gpr_we;
   wb_arch_pkg::reg_idx_t  gpr_dr;
   logic [`WB_DATA_W-1:0]  gpr_data;
   logic                   eip_we;
   logic [`WB_DATA_W-1:0]  eip;
   logic                   st_req;
   logic [`WB_DATA_W-1:0]  st_addr;
   logic [`WB_DATA_W-1:0]  st_data;

   modport src (output valid, gpr_we, gpr_dr, gpr_data, eip_we, eip, st_req, st_addr, st_data,
                input  ready);
   modport dst (input  valid, gpr_we, gpr_dr, gpr_data, eip_we, eip, st_req, st_addr, st_data,
                output ready);
endinterface

// ==== design/wb_uop_pkg.sv ====
package wb_uop_pkg;

   typedef enum logic [1:0] {
      KIND_ALU    = 2'd0,
      KIND_BRANCH = 2'd1,
      KIND_STORE  = 2'd2,
      KIND_HALT   = 2'd3
   } uop_kind_t;

   typedef enum logic [1:0] {
      COND_ALWAYS = 2'd0,
      COND_JNE    = 2'd1,
      COND_JNBE   = 2'd2,
      COND_NEVER  = 2'd3
   } br_cond_t;

   // alu view, also read for the kind of store and halt items
   // flags_mask bit 0 CF, bit 1 ZF, bit 2 SF, bit 3 OF
   typedef struct packed {
      uop_kind_t             kind;
      wb_arch_pkg::reg_idx_t dr;
      logic                  ld_gpr;
      logic                  ld_flags;
      logic                  pop_flags;
      logic                  cmovc;
      logic [3:0]            flags_mask;
      logic [2:0]            pad;
   } alu_view_t;

   // branch view
   typedef struct packed {
      uop_kind_t   kind;
      br_cond_t    cond;
      logic [11:0] pad;
   } br_view_t;

   // kind sits in the top two bits of both views
   typedef union packed {
      alu_view_t alu;
      br_view_t  br;
   } wb_ctrl_u;

endpackage

// ==== design/writeback_top.sv ====
`include "wb_settings.svh"

module writeback_top (
   input  logic                  CLK,
   input  logic                  rst_n,

   input  logic                  in_valid,
   output logic                  in_ready,
   input  wb_uop_pkg::wb_ctrl_u  in_ctrl,
   input  logic [`WB_DATA_W-1:0] in_result_a,
   input  logic [`WB_DATA_W-1:0] in_result_c,
   input  logic [`WB_DATA_W-1:0] in_alu_flags,
   input  logic [`WB_DATA_W-1:0] in_address,
   input  logic [`WB_DATA_W-1:0] in_neip,
   input  logic [`WB_DATA_W-1:0] in_neip_not_taken,

   output logic                  gpr_we,
   output wb_arch_pkg::reg_idx_t gpr_dr,
   output logic [`WB_DATA_W-1:0] gpr_data,
   output logic                  eip_we,
   output logic [`WB_DATA_W-1:0] eip,

   // data cache port
   output logic                  dc_write,
   output logic [`WB_DATA_W-1:0] dc_address,
   output logic [`WB_DATA_W-1:0] dc_data,
   input  logic                  dc_ready,

   output logic [`WB_DATA_W-1:0] flags,
   output logic                  halted
);

   wb_uop_if    uop_if ();
   wb_commit_if cmt_if ();

   wb_latch wb_latch_inst (
      .CLK               (CLK),
      .rst_n             (rst_n),
      .in_valid          (in_valid),
      .in_ready          (in_ready),
      .in_ctrl           (in_ctrl),
      .in_result_a       (in_result_a),
      .in_result_c       (in_result_c),
      .in_alu_flags      (in_alu_flags),
      .in_address        (in_address),
      .in_neip           (in_neip),
      .in_neip_not_taken (in_neip_not_taken),
      .uop               (uop_if.src)
   );

   wb_resolve wb_resolve_inst (
      .CLK    (CLK),
      .rst_n  (rst_n),
      .uop    (uop_if.dst),
      .cmt    (cmt_if.src),
      .flags  (flags),
      .halted (halted)
   );

   wb_commit wb_commit_inst (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .cmt        (cmt_if.dst),
      .gpr_we     (gpr_we),
      .gpr_dr     (gpr_dr),
      .gpr_data   (gpr_data),
      .eip_we     (eip_we),
      .eip        (eip),
      .dc_write   (dc_write),
      .dc_address (dc_address),
      .dc_data    (dc_data),
      .dc_ready   (dc_ready)
   );

endmodule

// ==== test/writeback_properties.sv ====
`include "wb_settings.svh"

module writeback_properties (
   input logic                  CLK,
   input logic                  rst_n,
   input logic                  in_ready,
   input logic                  gpr_we,
   input logic                  eip_we,
   input logic                  dc_write,
   input logic [`WB_DATA_W-1:0] dc_address,
   input logic [`WB_DATA_W-1:0] dc_data,
   input logic                  dc_ready,
   input logic                  halted
);
   timeunit 1ns;
   timeprecision 1ps;

   // synchronous reset clears outputs one edge later
   reset_outputs_low: assert property (@(posedge CLK)
      !rst_n |=> !in_ready && !gpr_we && !eip_we && !dc_write && !halted)
      else $error("outputs not low during reset");

   store_held_stable: assert property (@(posedge CLK) disable iff (!rst_n)
      dc_write && !dc_ready |=> dc_write && $stable(dc_address) && $stable(dc_data))
      else $error("pending store dropped or changed before dc_ready");

   quiet_after_halt: assert property (@(posedge CLK) disable iff (!rst_n)
      halted |-> !gpr_we && !eip_we && !dc_write)
      else $error("write committed while halted");

endmodule

bind writeback_top writeback_properties writeback_properties_inst (
   .CLK        (CLK),
   .rst_n      (rst_n),
   .in_ready   (in_ready),
   .gpr_we     (gpr_we),
   .eip_we     (eip_we),
   .dc_write   (dc_write),
   .dc_address (dc_address),
   .dc_data    (dc_data),
   .dc_ready   (dc_ready),
   .halted     (halted)
);

// ==== test/writeback_tb.sv ====
`include "wb_settings.svh"

module writeback_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_ITEMS        = 400;
   localparam int HALT_IDX       = N_ITEMS - 2;
   localparam int TIMEOUT_CYCLES = N_ITEMS * 20 + 200;
   localparam int W              = `WB_DATA_W;

   logic                  CLK;
   logic                  rst_n;
   logic                  in_valid;
   logic                  in_ready;
   wb_uop_pkg::wb_ctrl_u  in_ctrl;
   logic [W-1:0]          in_result_a;
   logic [W-1:0]          in_result_c;
   logic [W-1:0]          in_alu_flags;
   logic [W-1:0]          in_address;
   logic [W-1:0]          in_neip;
   logic [W-1:0]          in_neip_not_taken;
   logic                  gpr_we;
   wb_arch_pkg::reg_idx_t gpr_dr;
   logic [W-1:0]          gpr_data;
   logic                  eip_we;
   logic [W-1:0]          eip;
   logic                  dc_write;
   logic [W-1:0]          dc_address;
   logic [W-1:0]          dc_data;
   logic                  dc_ready;
   logic [W-1:0]          flags;
   logic                  halted;

   // expected {dr, data, flags}, {eip, flags} and {address, data}
   logic [`WB_REG_W+2*W-1:0] exp_gpr[$];
   logic [2*W-1:0]           exp_eip[$];
   logic [2*W-1:0]           exp_st[$];
   logic [W-1:0]             model_flags = `WB_FLAGS_RESET;
   logic                     model_halted = 1'b0;
   int                       seed = 5779;
   int                       dc_seed = 5779;
   int                       cycles = 0;

   writeback_top writeback_top_inst (.*);

   always #20 CLK = ~CLK;

   function automatic int rnd(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   task automatic fail_run(string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(string name, logic [W-1:0] expected, logic [W-1:0] actual);
      assert (expected === actual) else begin
         fail_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
      end
   endtask

   // mostly alu items; the one after the halt must never commit
   task automatic drive_item(int idx);
      wb_uop_pkg::wb_ctrl_u ctrl;
      int                   sel;
      ctrl = '0;
      sel  = rnd(10);
      if (idx == HALT_IDX) begin
         ctrl.alu.kind = wb_uop_pkg::KIND_HALT;
      end else if (idx > HALT_IDX || sel < 6) begin
         ctrl.alu.kind       = wb_uop_pkg::KIND_ALU;
         ctrl.alu.dr         = wb_arch_pkg::reg_idx_t'(rnd(8));
         ctrl.alu.ld_gpr     = idx > HALT_IDX || rnd(8) != 0;
         ctrl.alu.ld_flags   = rnd(2) != 0;
         ctrl.alu.pop_flags  = rnd(8) == 0;
         ctrl.alu.cmovc      = idx < HALT_IDX && rnd(4) == 0;
         ctrl.alu.flags_mask = 4'(rnd(16));
      end else if (sel < 8) begin
         ctrl.br.kind = wb_uop_pkg::KIND_BRANCH;
         ctrl.br.cond = wb_uop_pkg::br_cond_t'(rnd(4));
      end else begin
         ctrl.alu.kind = wb_uop_pkg::KIND_STORE;
      end
      in_valid          <= 1'b1;
      in_ctrl           <= ctrl;
      in_result_a       <= $random(seed);
      in_result_c       <= $random(seed);
      in_alu_flags      <= $random(seed);
      in_address        <= $random(seed);
      in_neip           <= $random(seed);
      in_neip_not_taken <= $random(seed);
   endtask

   // called on the acceptance edge, so in_* still hold the accepted item
   task automatic model_accept();
      int           pos[4];
      logic         taken;
      logic         we;
      pos = '{wb_arch_pkg::CF_BIT, wb_arch_pkg::ZF_BIT, wb_arch_pkg::SF_BIT,
              wb_arch_pkg::OF_BIT};
      if (model_halted) begin
         return;
      end
      case (in_ctrl.alu.kind)
         wb_uop_pkg::KIND_ALU: begin
            we = in_ctrl.alu.ld_gpr && (!in_ctrl.alu.cmovc || model_flags[pos[0]]);
            if (in_ctrl.alu.ld_flags && in_ctrl.alu.pop_flags) begin
               model_flags = in_result_a;
            end else if (in_ctrl.alu.ld_flags) begin
               for (int j = 0; j < 4; j++) begin
                  if (in_ctrl.alu.flags_mask[j]) begin
                     model_flags[pos[j]] = in_alu_flags[pos[j]];
                  end
               end
            end
            if (we) begin
               exp_gpr.push_back({in_ctrl.alu.dr, in_result_c, model_flags});
            end
         end
         wb_uop_pkg::KIND_BRANCH: begin
            case (in_ctrl.br.cond)
               wb_uop_pkg::COND_ALWAYS: taken = 1'b1;
               wb_uop_pkg::COND_JNE:    taken = !model_flags[pos[1]];
               wb_uop_pkg::COND_JNBE:   taken = !model_flags[pos[0]] && !model_flags[pos[1]];
               default:                 taken = 1'b0;
            endcase
            exp_eip.push_back({taken ? in_neip : in_neip_not_taken, model_flags});
         end
         wb_uop_pkg::KIND_STORE: exp_st.push_back({in_address, in_result_a});
         default: model_halted = 1'b1;
      endcase
   endtask

   always @(posedge CLK) begin
      dc_ready <= ($unsigned($random(dc_seed)) % 10) < 6;
   end

   always @(posedge CLK) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         fail_run("timeout: micro-ops did not drain");
      end
   end

   // output monitors
   always @(posedge CLK) begin
      logic [`WB_REG_W+2*W-1:0] g;
      logic [2*W-1:0]           e;
      logic [2*W-1:0]           s;
      if (rst_n && gpr_we) begin
         assert (exp_gpr.size() != 0) else fail_run("register write with no item expecting it");
         g = exp_gpr.pop_front();
         check_value("gpr_dr", g[2*W +: `WB_REG_W], gpr_dr);
         check_value("gpr_data", g[W +: W], gpr_data);
         check_value("flags after alu", g[0 +: W], flags);
      end
      if (rst_n && eip_we) begin
         assert (exp_eip.size() != 0) else fail_run("eip update with no branch expecting it");
         e = exp_eip.pop_front();
         check_value("branch eip", e[W +: W], eip);
         check_value("flags after branch", e[0 +: W], flags);
      end
      if (rst_n && dc_write && dc_ready) begin
         assert (exp_st.size() != 0) else fail_run("cache store with no store expecting it");
         s = exp_st.pop_front();
         check_value("dc_address", s[W +: W], dc_address);
         check_value("dc_data", s[0 +: W], dc_data);
      end
   end

   initial begin
      CLK               = 1'b0;
      rst_n             = 1'b0;
      in_valid          = 1'b0;
      in_ctrl           = '0;
      in_result_a       = '0;
      in_result_c       = '0;
      in_alu_flags      = '0;
      in_address        = '0;
      in_neip           = '0;
      in_neip_not_taken = '0;
      dc_ready          = 1'b0;
      repeat (5) @(posedge CLK);
      check_value("reset gpr_we", '0, gpr_we);
      check_value("reset eip_we", '0, eip_we);
      check_value("reset dc_write", '0, dc_write);
      check_value("reset halted", '0, halted);
      check_value("reset in_ready", '0, in_ready);
      check_value("reset flags", `WB_FLAGS_RESET, flags);
      rst_n <= 1'b1;
      for (int i = 0; i < N_ITEMS; i++) begin
         if (rnd(8) == 0) begin
            in_valid <= 1'b0;
            @(posedge CLK);
         end
         drive_item(i);
         @(posedge CLK);
         while (!in_ready) begin
            @(posedge CLK);
         end
         model_accept();
      end
      in_valid <= 1'b0;
      while (exp_gpr.size() + exp_eip.size() + exp_st.size() != 0) begin
         @(posedge CLK);
      end
      // stray writes from the item behind the halt would show up here
      repeat (10) @(posedge CLK);
      // alu items without a register write leave their flags unchecked until now
      check_value("final flags", model_flags, flags);
      if (halted === 1'b1 && in_ready === 1'b0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         fail_run("halted did not rise after the halt micro-op");
      end
   end

endmodule
